/* logic/controlUnit.sv */
// ####################################################################
// Opcode decode into control bits and a sign-extended immediate.
// Unknown opcodes decode as NOP. Writes are dropped while halted.
// ####################################################################
`timescale 1ns/1ps

module controlUnit
   import cpuPkg::*;
(
   input  wordT   instr,
   input  logic   halted,
   output logic   regWriteEn,
   output regIdxT writeRegAddr,
   output logic   lbi,
   output logic   link,
   output logic   bFlag,
   output logic   jFlag,
   output logic   jrFlag,
   output logic   halt,
   output wordT   imm
);

   opcodeT  opcode;
   immKindT immKind;
   logic    writeReq; // Instruction wants a register write.

   assign opcode = instr[15:11];

   always_comb begin
      writeReq     = 1'b0;
      writeRegAddr = '0;
      lbi          = 1'b0;
      link         = 1'b0;
      bFlag        = 1'b0;
      jFlag        = 1'b0;
      jrFlag       = 1'b0;
      halt         = 1'b0;
      immKind      = immNone;
      case (opcode)
         opHalt: halt = 1'b1;
         opNop: ; // Nothing to do.
         opAluR: begin
            writeReq     = 1'b1;
            writeRegAddr = instr[4:2]; // Rd of R-format.
         end
         opAddi, opSubi, opXori, opAndni: begin
            writeReq     = 1'b1;
            writeRegAddr = instr[7:5]; // Rd of I-format.
         end
         opLbi: begin
            writeReq     = 1'b1;
            writeRegAddr = instr[10:8];
            lbi          = 1'b1; // Immediate is the write data.
            immKind      = immSext8;
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            bFlag   = 1'b1; // Condition resolved in decode.
            immKind = immSext8;
         end
         opJ: begin
            jFlag   = 1'b1;
            immKind = immSext11;
         end
         opJal: begin
            jFlag        = 1'b1;
            link         = 1'b1;
            writeReq     = 1'b1;
            writeRegAddr = linkReg; // Return address to r7.
            immKind      = immSext11;
         end
         opJr: begin
            jFlag   = 1'b1;
            jrFlag  = 1'b1; // Target is register plus imm.
            immKind = immSext8;
         end
         opJalr: begin
            jFlag        = 1'b1;
            jrFlag       = 1'b1;
            link         = 1'b1;
            writeReq     = 1'b1;
            writeRegAddr = linkReg;
            immKind      = immSext8;
         end
         default: ; // Unsupported, treat as NOP.
      endcase
   end

   // Sign extension of the chosen field.
   always_comb begin
      case (immKind)
         immSext8:  imm = {{8{instr[7]}}, instr[7:0]};
         immSext11: imm = {{5{instr[10]}}, instr[10:0]};
         default:   imm = '0;
      endcase
   end

   assign regWriteEn = writeReq & ~halted; // Frozen after HALT.

endmodule

/* logic/cpuPkg.sv */
// ####################################################################
// Shared types and opcode encodings for the 16-bit front end.
// Opcodes live in instruction bits 15:11 and instructions are 2 bytes.
// ####################################################################
package cpuPkg;

   typedef logic [15:0] wordT;   // Register and immediate data.
   typedef logic [15:0] addrT;   // Byte address for PC and targets.
   typedef logic [2:0]  regIdxT; // One of eight registers.
   typedef logic [4:0]  opcodeT; // Instruction bits 15:11.

   // Which immediate field gets sign-extended.
   typedef enum logic [1:0] {
      immNone,    // No immediate, output is zero.
      immSext8,   // Bits 7:0.
      immSext11   // Bits 10:0.
   } immKindT;

   // Control instructions.
   localparam opcodeT opHalt  = 5'b00000;
   localparam opcodeT opNop   = 5'b00001;

   // Jumps, 11-bit displacement or register plus 8-bit immediate.
   localparam opcodeT opJ     = 5'b00100;
   localparam opcodeT opJr    = 5'b00101;
   localparam opcodeT opJal   = 5'b00110;
   localparam opcodeT opJalr  = 5'b00111;

   // I-format ALU group, destination in bits 7:5.
   localparam opcodeT opAddi  = 5'b01000;
   localparam opcodeT opSubi  = 5'b01001;
   localparam opcodeT opXori  = 5'b01010;
   localparam opcodeT opAndni = 5'b01011;

   // Conditional branches on the first source register.
   localparam opcodeT opBeqz  = 5'b01100;
   localparam opcodeT opBnez  = 5'b01101;
   localparam opcodeT opBltz  = 5'b01110;
   localparam opcodeT opBgez  = 5'b01111;

   // Load byte immediate, destination in bits 10:8.
   localparam opcodeT opLbi   = 5'b11000;

   // R-format ALU group, destination in bits 4:2.
   localparam opcodeT opAluR  = 5'b11011;

   localparam regIdxT linkReg = 3'd7; // JAL and JALR write here.

endpackage

/* logic/decodeStage.sv */
// ####################################################################
// Register addressing, write-data select and branch resolution.
// JAL and JALR force the first read to r7, so JALR jumps via r7.
// ####################################################################
`timescale 1ns/1ps

module decodeStage
   import cpuPkg::*;
#(
   parameter int NumRegs = 8
) (
   input  logic   clk,
   input  logic   rstN,
   input  wordT   instr,
   input  wordT   imm,
   input  wordT   wbData,
   input  addrT   linkAddr,
   input  regIdxT writeRegAddr,
   input  logic   regWriteEn,
   input  logic   lbi,
   input  logic   link,
   input  logic   bFlag,
   input  logic   jFlag,
   input  logic   halt,
   output wordT   reg1Data,
   output wordT   reg2Data,
   output logic   pcSel
);

   regIdxT rs;
   regIdxT rt;
   wordT   writeData;
   logic   zeroFlag;  // First source equals zero.
   logic   signFlag;  // First source is negative.
   logic   taken;     // Branch condition holds.

   // JAL and JALR read r7, all else read bits 10:8.
   assign rs = (instr[15:11] == opJal || instr[15:11] == opJalr) ? linkReg : instr[10:8];
   assign rt = instr[7:5];

   // Link beats LBI, else the external writeback.
   assign writeData = link ? linkAddr : (lbi ? imm : wbData);

   regFile #(
      .NumRegs(NumRegs)
   ) regFile_inst (
      .clk      (clk),
      .rstN     (rstN),
      .readReg1 (rs),
      .readReg2 (rt),
      .writeReg (writeRegAddr),
      .writeData(writeData),
      .writeEn  (regWriteEn),
      .readData1(reg1Data),
      .readData2(reg2Data)
   );

   assign zeroFlag = (reg1Data == '0);
   assign signFlag = reg1Data[15];

   // Low opcode bits pick the condition.
   always_comb begin
      case (instr[12:11])
         2'b00:   taken = zeroFlag;  // BEQZ.
         2'b01:   taken = ~zeroFlag; // BNEZ.
         2'b10:   taken = signFlag;  // BLTZ.
         default: taken = ~signFlag; // BGEZ.
      endcase
   end

   assign pcSel = ~halt & ((bFlag & taken) | jFlag);

endmodule

/* logic/frontEnd.sv */
// ####################################################################
// Top of the front end. Instruction memory answers pc in the same
// cycle, and the external ALU result returns on wbData.
// ####################################################################
`timescale 1ns/1ps

module frontEnd
   import cpuPkg::*;
#(
   parameter int   NumRegs = 8,
   parameter addrT ResetPc = '0
) (
   input  logic clk,
   input  logic rstN,
   input  wordT instr,
   input  wordT wbData,
   output addrT pc,
   output wordT reg1Data,
   output wordT reg2Data,
   output wordT imm,
   output logic halted
);

   logic   regWriteEn;
   regIdxT writeRegAddr;
   logic   lbi;
   logic   link;
   logic   bFlag;
   logic   jFlag;
   logic   jrFlag;
   logic   halt;
   logic   pcSel;
   addrT   linkAddr;

   controlUnit controlUnit_inst (
      .instr       (instr),
      .halted      (halted),
      .regWriteEn  (regWriteEn),
      .writeRegAddr(writeRegAddr),
      .lbi         (lbi),
      .link        (link),
      .bFlag       (bFlag),
      .jFlag       (jFlag),
      .jrFlag      (jrFlag),
      .halt        (halt),
      .imm         (imm)
   );

   decodeStage #(
      .NumRegs(NumRegs)
   ) decodeStage_inst (
      .clk         (clk),
      .rstN        (rstN),
      .instr       (instr),
      .imm         (imm),
      .wbData      (wbData),
      .linkAddr    (linkAddr),
      .writeRegAddr(writeRegAddr),
      .regWriteEn  (regWriteEn),
      .lbi         (lbi),
      .link        (link),
      .bFlag       (bFlag),
      .jFlag       (jFlag),
      .halt        (halt),
      .reg1Data    (reg1Data),
      .reg2Data    (reg2Data),
      .pcSel       (pcSel)
   );

   pcUnit #(
      .ResetPc(ResetPc)
   ) pcUnit_inst (
      .clk     (clk),
      .rstN    (rstN),
      .pcSel   (pcSel),
      .jrFlag  (jrFlag),
      .halt    (halt),
      .imm     (imm),
      .reg1Data(reg1Data),
      .pc      (pc),
      .linkAddr(linkAddr),
      .halted  (halted)
   );

endmodule

/* logic/pcUnit.sv */
// ####################################################################
// PC register, link address, jump and branch targets, halt state.
// HALT advances the PC once, then the PC holds until reset.
// ####################################################################
`timescale 1ns/1ps

module pcUnit
   import cpuPkg::*;
#(
   parameter addrT ResetPc = '0
) (
   input  logic clk,
   input  logic rstN,
   input  logic pcSel,
   input  logic jrFlag,
   input  logic halt,
   input  wordT imm,
   input  wordT reg1Data,
   output addrT pc,
   output addrT linkAddr,
   output logic halted
);

   addrT pcPlus2;
   addrT relTarget; // PC+2 plus displacement.
   addrT regTarget; // Register plus immediate.
   addrT nextPc;

   assign pcPlus2   = pc + addrT'(2); // Instructions are 2 bytes.
   assign linkAddr  = pcPlus2;        // Return address for JAL/JALR.
   assign relTarget = pcPlus2 + imm;
   assign regTarget = reg1Data + imm;

   always_comb begin
      if (!pcSel) begin
         nextPc = pcPlus2; // Sequential flow.
      end else if (jrFlag) begin
         nextPc = regTarget;
      end else begin
         nextPc = relTarget;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc     <= ResetPc;
         halted <= 1'b0;
      end else if (!halted) begin
         pc <= nextPc;
         if (halt) begin
            halted <= 1'b1; // Sticky until reset.
         end
      end
   end

endmodule

/* logic/regFile.sv */
// ####################################################################
// Register file with two combinational reads and one clocked write.
// A read in the cycle of a write to the same register sees old data.
// ####################################################################
`timescale 1ns/1ps

module regFile
   import cpuPkg::*;
#(
   parameter int NumRegs = 8
) (
   input  logic   clk,
   input  logic   rstN,
   input  regIdxT readReg1,
   input  regIdxT readReg2,
   input  regIdxT writeReg,
   input  wordT   writeData,
   input  logic   writeEn,
   output wordT   readData1,
   output wordT   readData2
);

   wordT regs [NumRegs]; // Architectural registers.

   // Synchronous clear, then one write per edge.
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0; // All registers start at zero.
         end
      end else if (writeEn) begin
         regs[writeReg] <= writeData; // Lands at the end of the cycle.
      end
   end

   // Reads bypass nothing, so old value on same-cycle write.
   assign readData1 = regs[readReg1]; // First source, Rs.
   assign readData2 = regs[readReg2]; // Second source, Rt.

endmodule

/* project.f */
+incdir+tests
logic/cpuPkg.sv
logic/regFile.sv
logic/controlUnit.sv
logic/decodeStage.sv
logic/pcUnit.sv
logic/frontEnd.sv
tests/frontEndTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the front-end testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module frontEndTb -o frontEndSim

output="$(./obj_dir/frontEndSim)"
echo "${output}"

if grep -q "ALL CHECKS PASSED" <<< "${output}"; then
   exit 0
fi
exit 1

/* tests/frontEndModel.svh */
// ####################################################################
// Reference model and program generator, included by the testbench.
// Programs only jump forward, so every run reaches the HALT at word 127.
// ####################################################################
`ifndef FRONT_END_MODEL_SVH
`define FRONT_END_MODEL_SVH

wordT        imem [128];       // Instruction memory, word indexed.
bit          jumpTarget [128]; // Words that some jump lands on.
logic [31:0] randState;        // LCG state.
wordT        modelRegs [8];    // Architectural registers.
addrT        modelPc;
logic        modelHalted;

function automatic int lcgNext();
   randState = randState * 32'd1664525 + 32'd1013904223;
   return int'(randState[31:16]); // Upper half has the better bits.
endfunction

// Sign extension by instruction form. I-format ALU carries no immediate.
function automatic wordT expectImm(input wordT ins);
   opcodeT op;
   op = ins[15:11];
   if (op == opJ || op == opJal) begin
      return {{5{ins[10]}}, ins[10:0]}; // 11-bit displacement.
   end else if (op == opLbi || op == opJr || op == opJalr || op[4:2] == 3'b011) begin
      return {{8{ins[7]}}, ins[7:0]};   // 8-bit field, branches too.
   end
   return 16'h0;
endfunction

function automatic void resetModel();
   for (int i = 0; i < 8; i++) begin
      modelRegs[i] = 16'h0;
   end
   modelPc     = 16'h0;
   modelHalted = 1'b0;
endfunction

// One instruction's effect on the model state.
function automatic void executeModel(input wordT ins, input wordT wb);
   opcodeT op;
   wordT   immV;
   wordT   rsV;
   addrT   seqPc;
   op    = ins[15:11];
   immV  = expectImm(ins);
   rsV   = modelRegs[ins[10:8]];
   seqPc = modelPc + 16'd2;
   if (modelHalted) begin
      return; // Frozen until reset.
   end
   modelPc = seqPc; // HALT still advances once.
   case (op)
      opHalt: modelHalted = 1'b1;
      opAluR: modelRegs[ins[4:2]] = wb;
      opAddi, opSubi, opXori, opAndni: modelRegs[ins[7:5]] = wb;
      opLbi: modelRegs[ins[10:8]] = immV;
      opBeqz: if (rsV == 16'h0) modelPc = seqPc + immV;
      opBnez: if (rsV != 16'h0) modelPc = seqPc + immV;
      opBltz: if (rsV[15]) modelPc = seqPc + immV;
      opBgez: if (!rsV[15]) modelPc = seqPc + immV;
      opJ: modelPc = seqPc + immV;
      opJr: modelPc = rsV + immV;
      opJal: begin
         modelPc            = seqPc + immV;
         modelRegs[linkReg] = seqPc;
      end
      opJalr: begin
         modelPc            = modelRegs[linkReg] + immV; // Old r7.
         modelRegs[linkReg] = seqPc;
      end
      default: ; // Anything else is a NOP.
   endcase
endfunction

// Random forward-only program. JR and JALR come as LBI plus jump pairs.
task automatic buildProgram();
   int     a;
   int     kind;
   int     d;
   int     tw;
   wordT   disp;
   wordT   half;
   regIdxT rx;
   for (a = 0; a < 128; a++) begin
      jumpTarget[a] = 1'b0;
   end
   for (a = 0; a < 4; a++) begin
      imem[a] = {opNop, regIdxT'(2 * a), regIdxT'(2 * a + 1), 5'h0}; // Read pairs.
   end
   a = 4;
   while (a < 127) begin
      kind = lcgNext() % 8;
      d    = lcgNext() % ((127 - a < 8) ? 127 - a : 8); // Words skipped.
      disp = wordT'(2 * d);
      rx   = regIdxT'(lcgNext() % 8);
      if (kind == 7 && (a > 125 || jumpTarget[a + 1])) begin
         kind = 0; // A pair must not be entered halfway.
      end
      case (kind)
         0, 1: imem[a] = {opAluR, 11'(lcgNext())};
         2, 3: imem[a] = {opcodeT'(opAddi + lcgNext() % 4), 11'(lcgNext())};
         4: imem[a] = {opLbi, 11'(lcgNext())};
         5: begin
            imem[a]                = {opcodeT'(opBeqz + lcgNext() % 4), rx, disp[7:0]};
            jumpTarget[a + 1 + d]  = 1'b1;
         end
         6: begin
            imem[a]                = {(lcgNext() % 2 == 1) ? opJal : opJ, disp[10:0]};
            jumpTarget[a + 1 + d]  = 1'b1;
         end
         default: begin
            tw   = a + 2 + lcgNext() % ((126 - a < 8) ? 126 - a : 8);
            half = wordT'(tw); // Register and immediate each give half.
            if (lcgNext() % 2 == 1) begin
               imem[a]     = {opLbi, linkReg, half[7:0]};
               imem[a + 1] = {opJalr, 3'(lcgNext()), half[7:0]}; // Field ignored.
            end else begin
               imem[a]     = {opLbi, rx, half[7:0]};
               imem[a + 1] = {opJr, rx, half[7:0]};
            end
            jumpTarget[tw] = 1'b1;
            a++;
         end
      endcase
      a++;
   end
   imem[127] = {opHalt, 11'h0};
endtask

`endif

/* tests/frontEndTb.sv */
// ####################################################################
// Testbench for the front end with a 128-word instruction memory.
// Inputs change on the falling edge, checks run mid low phase.
// ####################################################################
`timescale 1ns/1ps

module frontEndTb
   import cpuPkg::*;
();

   localparam int MaxCycles = 300; // Programs finish well below this.

   logic clk;
   logic rstN;
   wordT instr;
   wordT wbData;
   addrT pc;
   wordT reg1Data;
   wordT reg2Data;
   wordT imm;
   logic halted;
   int   errors = 0;

   `include "frontEndModel.svh"

   frontEnd frontEnd_inst (
      .clk     (clk),
      .rstN    (rstN),
      .instr   (instr),
      .wbData  (wbData),
      .pc      (pc),
      .reg1Data(reg1Data),
      .reg2Data(reg2Data),
      .imm     (imm),
      .halted  (halted)
   );

   always #10 clk = ~clk; // 20 ns period.

   task automatic checkWord(input string name, input wordT got, input wordT exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic checkAddr(input string name, input addrT got, input addrT exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s got %h expected %h", name, got, exp);
      end
   endtask

   // Called on a falling edge, returns on the next one.
   task automatic stepCycle(input wordT ins);
      wordT   wb;
      regIdxT ra;
      wb     = wordT'(lcgNext());
      instr  = ins;
      wbData = wb;
      #5;
      ra = (ins[15:11] == opJal || ins[15:11] == opJalr) ? linkReg : ins[10:8];
      checkAddr("pc", pc, modelPc);
      checkFlag("halted", halted, modelHalted);
      checkWord("reg1Data", reg1Data, modelRegs[ra]);
      checkWord("reg2Data", reg2Data, modelRegs[ins[7:5]]);
      checkWord("imm", imm, expectImm(ins));
      executeModel(ins, wb);
      @(negedge clk);
   endtask

   initial begin
      int cycles;
      clk       = 1'b0;
      rstN      = 1'b0;
      instr     = {opNop, 11'h0};
      wbData    = 16'h0;
      randState = 32'h96b8;
      buildProgram();
      resetModel();
      repeat (5) @(negedge clk); // Five reset edges.
      rstN   = 1'b1;
      cycles = 0;
      while (halted !== 1'b1 && cycles < MaxCycles) begin
         stepCycle(imem[pc[7:1]]);
         cycles++;
      end
      if (halted !== 1'b1) begin
         errors++;
         $display("Timeout: halted did not rise within %0d cycles", MaxCycles);
      end else begin
         // Random words while halted must change nothing.
         repeat (10) begin
            stepCycle(wordT'(lcgNext()));
         end
         for (int i = 0; i < 4; i++) begin
            stepCycle({opNop, regIdxT'(2 * i), regIdxT'(2 * i + 1), 5'h0});
         end
      end
      $display("Summary: %0d errors after %0d instructions", errors, cycles);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
